//--- iop_dispatch.f
source/iop_dispatch_pkg.sv
source/sync_fifo.sv
source/dop_builder.sv
source/ack_matcher.sv
source/dispatch_ctrl.sv
source/iop_dispatch.sv
verif/tb_clock_gen.sv
verif/tb_iop_dispatch.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_iop_dispatch
FILELIST = iop_dispatch.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

//--- verif/iop_cases.txt
// IOp word, expected number of element DOps
// opcode_count_dst_src   element_count
01031020 00000003
02023040 00000002
0304fefc 00000004
07051122 00000000
01005060 00000000
03017080 00000001
0205a0b0 00000005
0102ffff 00000002
00030102 00000000
03062021 00000006
0201c0d0 00000001
01040809 00000004

//--- verif/tb_iop_dispatch.sv
/*
 * Testbench for the IOp dispatch core
 * Host driver, scheduler model with random stalls, and DOp/ack checks
 */

module tb_iop_dispatch
  import iop_dispatch_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCASES  = 12;
  localparam int TIMEOUT = 2000;

  logic  clk;
  logic  rst;
  inst_t workq_wdata = '0;
  logic  workq_wr_en = 1'b0;
  logic  workq_full;
  inst_t ackq_data;
  logic  ackq_empty;
  logic  ackq_rd_en = 1'b0;
  inst_t dop_data;
  logic  dop_vld;
  logic  dop_rdy = 1'b0;
  inst_t ack_data = '0;
  logic  ack_vld = 1'b0;
  logic  ack_rdy;
  logic  ack_err;

  logic [31:0] case_mem [2*NCASES];
  logic [31:0] lcg_state = 32'h34d30e97;
  inst_t       got_dops [$];
  inst_t       ack_pend [$];
  inst_t       popped [$];
  inst_t       sync_words [$];
  bit          hold_rdy_low = 1'b1;
  bit          corrupt_ack = 1'b0;
  bit          ack_taken = 1'b0;
  int          ack_delay = 0;

  tb_clock_gen clock_gen (
    .clk (clk),
    .rst (rst)
  );

  iop_dispatch iop_dispatch_inst (
    .clk         (clk        ),
    .rst         (rst        ),
    .workq_wdata (workq_wdata),
    .workq_wr_en (workq_wr_en),
    .workq_full  (workq_full ),
    .ackq_data   (ackq_data  ),
    .ackq_empty  (ackq_empty ),
    .ackq_rd_en  (ackq_rd_en ),
    .dop_data    (dop_data   ),
    .dop_vld     (dop_vld    ),
    .dop_rdy     (dop_rdy    ),
    .ack_data    (ack_data   ),
    .ack_vld     (ack_vld    ),
    .ack_rdy     (ack_rdy    ),
    .ack_err     (ack_err    )
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Element DOp as given by the opcode table and operand stepping
  function automatic inst_t model_dop(input inst_t iop, input int k, input int tag);
    logic [3:0] kind;
    logic [7:0] dst;
    logic [7:0] src;
    case (iop[31:24])
      IOP_ADD:  kind = DOP_ADD;
      IOP_MUL:  kind = DOP_MUL;
      IOP_COPY: kind = DOP_COPY;
      default:  kind = DOP_NOP;
    endcase
    dst = iop[15:8] + 8'(k);
    src = iop[7:0] + 8'(k);
    return {kind, dst, src, 4'h0, 8'(tag)};
  endfunction

  function automatic int model_count(input inst_t iop);
    if (iop[31:24] == IOP_ADD || iop[31:24] == IOP_MUL || iop[31:24] == IOP_COPY)
      return int'(iop[23:16]);
    return 0;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // Starts and ends on a falling edge
  task automatic push_iop(input inst_t word);
    int n;
    n = 0;
    while (workq_full) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout("room in the work queue");
    end
    workq_wdata = word;
    workq_wr_en = 1'b1;
    @(negedge clk);
    workq_wr_en = 1'b0;
  endtask

  task automatic wait_popped(input int total);
    int n;
    n = 0;
    while (popped.size() < total) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout("ack queue words");
    end
  endtask

  // ========================================
  // Scheduler and host ack side models
  // ========================================
  always @(posedge clk) begin
    ack_taken = ack_vld && ack_rdy;
    if (ack_taken) void'(ack_pend.pop_front());
    if (dop_vld && dop_rdy) begin
      got_dops.push_back(dop_data);
      // Injected error flips tag bits of the returned ack
      if (dop_data[31:28] == DOP_SYNC)
        ack_pend.push_back(corrupt_ack ? (dop_data ^ 32'h0000_00a5) : dop_data);
    end
    if (ackq_rd_en && !ackq_empty) popped.push_back(ackq_data);
  end

  always @(negedge clk) begin
    if (!rst) begin
      dop_rdy    = hold_rdy_low ? 1'b0 : ((lcg_next() >> 30) != 0);
      ackq_rd_en = !ackq_empty;
      if (ack_taken) ack_vld = 1'b0;
      if (!ack_vld && ack_pend.size() > 0) begin
        if (ack_delay == 0) begin
          ack_vld   = 1'b1;
          ack_data  = ack_pend[0];
          ack_delay = lcg_next() % 5;
        end else begin
          ack_delay--;
        end
      end
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int    n;
    int    pos;
    int    cnt;
    inst_t exp_sync;
    $readmemh("verif/iop_cases.txt", case_mem);

    // Reset values
    @(posedge clk);
    @(negedge clk);
    check_equal(dop_vld, 0, "dop_vld in reset");
    check_equal(ack_rdy, 1, "ack_rdy in reset");
    check_equal(ackq_empty, 1, "ackq_empty in reset");
    check_equal(ack_err, 0, "ack_err in reset");
    n = 0;
    while (rst) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout("reset release");
    end
    check_equal(dop_vld, 0, "dop_vld after reset");
    check_equal(ack_rdy, 1, "ack_rdy after reset");
    check_equal(ackq_empty, 1, "ackq_empty after reset");
    check_equal(ack_err, 0, "ack_err after reset");

    // Controller takes case 0 and stalls
    push_iop(case_mem[0]);
    n = 0;
    while (!iop_dispatch_inst.work_q.empty || !dop_vld) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout("the controller to take the first IOp");
    end
    // Remaining cases fill the work queue
    for (int i = 1; i <= WORKQ_DEPTH; i++) begin
      check_equal(workq_full, 0, "workq_full before fill completes");
      push_iop(case_mem[2*i]);
    end
    check_equal(workq_full, 1, "workq_full after filling");

    hold_rdy_low = 1'b0;
    for (int i = WORKQ_DEPTH + 1; i < NCASES; i++) push_iop(case_mem[2*i]);
    wait_popped(NCASES);

    // DOp stream per IOp
    pos = 0;
    for (int i = 0; i < NCASES; i++) begin
      cnt = int'(case_mem[2*i+1]);
      check_equal(model_count(case_mem[2*i]), cnt, $sformatf("element count, case %0d", i));
      for (int k = 0; k < cnt; k++) begin
        check_equal(pos < got_dops.size(), 1,
                    $sformatf("element DOp %0d of case %0d received", k, i));
        check_equal(got_dops[pos], model_dop(case_mem[2*i], k, i),
                    $sformatf("element DOp %0d of case %0d", k, i));
        pos++;
      end
      check_equal(pos < got_dops.size(), 1, $sformatf("SYNC of case %0d received", i));
      exp_sync = {DOP_SYNC, 8'h00, 8'h00, 4'h0, 8'(i)};
      check_equal(got_dops[pos], exp_sync, $sformatf("SYNC of case %0d", i));
      sync_words.push_back(exp_sync);
      pos++;
    end
    check_equal(got_dops.size(), pos, "total DOp count");

    // Completion order
    for (int i = 0; i < NCASES; i++)
      check_equal(popped[i], sync_words[i], $sformatf("ack queue word %0d", i));
    @(negedge clk);
    check_equal(ackq_empty, 1, "ackq_empty at end of run");
    check_equal(ack_err, 0, "ack_err after matched acks");

    // Unknown opcode gives a bare SYNC, its ack returns with a wrong tag
    corrupt_ack = 1'b1;
    push_iop(32'h07000000);
    wait_popped(NCASES + 1);
    check_equal(popped[NCASES], {DOP_SYNC, 8'h00, 8'h00, 4'h0, 8'(NCASES) ^ 8'ha5},
                "ack queue word with wrong tag");
    check_equal(ack_err, 1, "ack_err after wrong tag");
    repeat (4) @(negedge clk);
    check_equal(ack_err, 1, "ack_err stays set");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verif/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 8 ns clock, reset held high for the first 3 rising edges
 */

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- source/iop_dispatch.sv
/*
 * IOp dispatch core top level
 * Work and ack queues around the DOp translation controller
 */

module iop_dispatch
  import iop_dispatch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // Host work queue
  input  inst_t workq_wdata,
  input  logic  workq_wr_en,
  output logic  workq_full,

  // Host ack queue
  output inst_t ackq_data,
  output logic  ackq_empty,
  input  logic  ackq_rd_en,

  // DOp stream to the scheduler
  output inst_t dop_data,
  output logic  dop_vld,
  input  logic  dop_rdy,

  // Ack stream from the scheduler
  input  inst_t ack_data,
  input  logic  ack_vld,
  output logic  ack_rdy,
  output logic  ack_err
);

  inst_t                  workq_head;
  logic                   workq_empty;
  logic                   workq_pop;
  inst_t                  cur_iop;
  logic [IOP_FIELD_W-1:0] elem_idx;
  logic                   is_sync;
  logic [TAG_W-1:0]       cur_tag;
  inst_t                  dop_next;
  logic                   tag_push;
  logic [SYNC_CNT_W-1:0]  outstanding;
  logic                   ackq_full;
  logic                   ack_take;

  assign ack_rdy  = !ackq_full;
  assign ack_take = ack_vld && ack_rdy;

  // ========================================
  // Queues
  // ========================================
  sync_fifo #(
    .payload_t (inst_t),
    .DEPTH     (WORKQ_DEPTH)
  ) work_q (
    .clk   (clk        ),
    .rst   (rst        ),
    .wr_en (workq_wr_en),
    .rd_en (workq_pop  ),
    .wdata (workq_wdata),
    .rdata (workq_head ),
    .empty (workq_empty),
    .full  (workq_full )
  );

  // Every ack is queued, matched or not
  sync_fifo #(
    .payload_t (inst_t),
    .DEPTH     (ACKQ_DEPTH)
  ) ack_q (
    .clk   (clk       ),
    .rst   (rst       ),
    .wr_en (ack_take  ),
    .rd_en (ackq_rd_en),
    .wdata (ack_data  ),
    .rdata (ackq_data ),
    .empty (ackq_empty),
    .full  (ackq_full )
  );

  // ========================================
  // Translation and completion
  // ========================================
  dop_builder dop_builder (
    .iop      (cur_iop ),
    .elem_idx (elem_idx),
    .is_sync  (is_sync ),
    .tag      (cur_tag ),
    .dop      (dop_next)
  );

  ack_matcher ack_matcher (
    .clk         (clk        ),
    .rst         (rst        ),
    .tag_push    (tag_push   ),
    .tag_in      (cur_tag    ),
    .ack_take    (ack_take   ),
    .ack_word    (ack_data   ),
    .outstanding (outstanding),
    .ack_err     (ack_err    )
  );

  dispatch_ctrl dispatch_ctrl (
    .clk         (clk        ),
    .rst         (rst        ),
    .workq_head  (workq_head ),
    .workq_empty (workq_empty),
    .dop_next    (dop_next   ),
    .dop_rdy     (dop_rdy    ),
    .outstanding (outstanding),
    .workq_pop   (workq_pop  ),
    .cur_iop     (cur_iop    ),
    .elem_idx    (elem_idx   ),
    .is_sync     (is_sync    ),
    .cur_tag     (cur_tag    ),
    .dop_data    (dop_data   ),
    .dop_vld     (dop_vld    ),
    .tag_push    (tag_push   )
  );

endmodule

//--- source/dispatch_ctrl.sv
/*
 * Dispatch controller
 * Fetches IOps, issues their element DOps and closing SYNC on the DOp stream
 */

module dispatch_ctrl
  import iop_dispatch_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  inst_t                  workq_head,
  input  logic                   workq_empty,
  input  inst_t                  dop_next,
  input  logic                   dop_rdy,
  input  logic [SYNC_CNT_W-1:0]  outstanding,
  output logic                   workq_pop,
  output inst_t                  cur_iop,
  output logic [IOP_FIELD_W-1:0] elem_idx,
  output logic                   is_sync,
  output logic [TAG_W-1:0]       cur_tag,
  output inst_t                  dop_data,
  output logic                   dop_vld,
  output logic                   tag_push
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    SYNC
  } state_t;

  state_t                 state;
  logic [IOP_FIELD_W-1:0] elem_cnt;
  logic                   slot_free;
  logic                   sync_out;
  logic                   sync_room;
  logic                   load;

  // ========================================
  // Output slot and issue decisions
  // ========================================
  // Slot frees up on the same edge as a transfer
  assign slot_free = !dop_vld || dop_rdy;
  assign sync_out  = dop_vld && (dop_data[DOP_KIND_LSB +: DOP_KIND_W] == DOP_SYNC);
  assign sync_room = (outstanding < SYNC_CNT_W'(SYNC_MAX));

  // Unknown opcodes skip straight to the SYNC
  assign elem_cnt = (iop_to_dop_kind(cur_iop[IOP_OPC_LSB +: IOP_FIELD_W]) == DOP_NOP) ?
                    '0 : cur_iop[IOP_CNT_LSB +: IOP_FIELD_W];

  assign load = slot_free &&
                (((state == ISSUE) && (elem_idx != elem_cnt)) ||
                 ((state == SYNC) && !sync_out && sync_room));

  assign workq_pop = (state == IDLE) && !workq_empty;
  assign is_sync   = (state == SYNC);
  assign tag_push  = sync_out && dop_rdy;

  // ========================================
  // FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      elem_idx <= '0;
      cur_tag  <= '0;
      dop_vld  <= 1'b0;
    end else begin
      if (load) dop_vld <= 1'b1;
      else if (dop_rdy) dop_vld <= 1'b0;

      case (state)
        IDLE: begin
          if (!workq_empty) begin
            elem_idx <= '0;
            state    <= ISSUE;
          end
        end
        ISSUE: begin
          // Index moves as each element DOp enters the output register
          if (elem_idx == elem_cnt) state <= SYNC;
          else if (load) elem_idx <= elem_idx + 1'b1;
        end
        SYNC: begin
          // Tag advances only once the SYNC has left
          if (tag_push) begin
            cur_tag <= cur_tag + 1'b1;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // IOp latch and DOp output register
  always_ff @(posedge clk) begin
    if (workq_pop) cur_iop <= workq_head;
    if (load) dop_data <= dop_next;
  end

  dop_hold : assert property (@(posedge clk) disable iff (rst)
    (dop_vld && !dop_rdy) |=> (dop_vld && $stable(dop_data)))
    else $error("DOp dropped or changed while stalled");

endmodule

//--- source/ack_matcher.sv
/*
 * In-order sync tag tracker
 * Checks each returned ack against the oldest outstanding SYNC tag
 */

module ack_matcher
  import iop_dispatch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  tag_push,
  input  logic [TAG_W-1:0]      tag_in,
  input  logic                  ack_take,
  input  inst_t                 ack_word,
  output logic [SYNC_CNT_W-1:0] outstanding,
  output logic                  ack_err
);

  logic [TAG_W-1:0]      tag_mem [SYNC_MAX];
  // SYNC_MAX is a power of two, pointers wrap on their own
  logic [SYNC_PTR_W-1:0] wr_ptr;
  logic [SYNC_PTR_W-1:0] rd_ptr;
  logic [SYNC_CNT_W-1:0] count;
  logic                  pop;
  logic                  mismatch;

  assign pop         = ack_take && (count != '0);
  assign mismatch    = (ack_word[DOP_KIND_LSB +: DOP_KIND_W] != DOP_SYNC) ||
                       (ack_word[DOP_TAG_LSB +: TAG_W] != tag_mem[rd_ptr]);
  assign outstanding = count;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      ack_err <= 1'b0;
    end else begin
      if (tag_push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (tag_push && !pop) count <= count + 1'b1;
      else if (pop && !tag_push) count <= count - 1'b1;
      // Sticky, also covers an ack with nothing outstanding
      if (ack_take && ((count == '0) || mismatch)) ack_err <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_push) tag_mem[wr_ptr] <= tag_in;
  end

  // Controller holds SYNCs back at SYNC_MAX
  no_push_when_full : assert property (@(posedge clk) disable iff (rst)
    tag_push |-> (count < SYNC_CNT_W'(SYNC_MAX)))
    else $error("tag pushed into full sync store");

endmodule

//--- source/dop_builder.sv
/*
 * DOp word builder
 * Combinational mapping of the current IOp, element index and tag to one DOp
 */

module dop_builder
  import iop_dispatch_pkg::*;
(
  input  inst_t                  iop,
  input  logic [IOP_FIELD_W-1:0] elem_idx,
  input  logic                   is_sync,
  input  logic [TAG_W-1:0]       tag,
  output inst_t                  dop
);

  logic [DOP_KIND_W-1:0]  kind;
  logic [IOP_FIELD_W-1:0] dst;
  logic [IOP_FIELD_W-1:0] src;

  // ========================================
  // Field selection
  // ========================================
  always_comb begin
    kind = iop_to_dop_kind(iop[IOP_OPC_LSB +: IOP_FIELD_W]);
    // Operand addresses wrap modulo 256
    dst  = iop[IOP_DST_LSB +: IOP_FIELD_W] + elem_idx;
    src  = iop[IOP_SRC_LSB +: IOP_FIELD_W] + elem_idx;

    // Sync closes the run, no operands
    if (is_sync) begin
      kind = DOP_SYNC;
      dst  = '0;
      src  = '0;
    end
  end

  // ========================================
  // Word packing
  // ========================================
  always_comb begin
    dop = '0;
    dop[DOP_KIND_LSB +: DOP_KIND_W]   = kind;
    dop[DOP_DST_LSB +: IOP_FIELD_W]   = dst;
    dop[DOP_SRC_LSB +: IOP_FIELD_W]   = src;
    // Reserved
    dop[DOP_FLAGS_LSB +: DOP_FLAGS_W] = '0;
    dop[DOP_TAG_LSB +: TAG_W]         = tag;
  end

endmodule

//--- source/sync_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO
 * Head word is always on rdata; overflow writes and underflow reads are dropped
 */

module sync_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  logic     rd_en,
  input  payload_t wdata,
  output payload_t rdata,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Wrap explicitly so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wdata;
  end

  occupancy_bound : assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(DEPTH))
    else $error("sync_fifo occupancy above DEPTH");

endmodule

//--- source/iop_dispatch_pkg.sv
/*
 * IOp dispatch core shared definitions
 * Word widths, IOp/DOp field positions, opcode codes and queue depths
 */

package iop_dispatch_pkg;

  // ========================================
  // Word and field layout
  // ========================================
  localparam int PE_INST_W = 32;
  typedef logic [PE_INST_W-1:0] inst_t;

  // IOp fields, all 8 bits wide
  localparam int IOP_FIELD_W = 8;
  localparam int IOP_OPC_LSB = 24;
  localparam int IOP_CNT_LSB = 16;
  localparam int IOP_DST_LSB = 8;
  localparam int IOP_SRC_LSB = 0;

  // DOp fields, dst and src reuse the IOp field width
  localparam int DOP_KIND_W    = 4;
  localparam int DOP_KIND_LSB  = 28;
  localparam int DOP_DST_LSB   = 20;
  localparam int DOP_SRC_LSB   = 12;
  localparam int DOP_FLAGS_W   = 4;
  localparam int DOP_FLAGS_LSB = 8;
  localparam int DOP_TAG_LSB   = 0;
  localparam int TAG_W         = 8;

  // ========================================
  // Opcodes
  // ========================================
  localparam logic [IOP_FIELD_W-1:0] IOP_ADD  = 8'h01;
  localparam logic [IOP_FIELD_W-1:0] IOP_MUL  = 8'h02;
  localparam logic [IOP_FIELD_W-1:0] IOP_COPY = 8'h03;

  localparam logic [DOP_KIND_W-1:0] DOP_NOP  = 4'h0;
  localparam logic [DOP_KIND_W-1:0] DOP_ADD  = 4'h1;
  localparam logic [DOP_KIND_W-1:0] DOP_MUL  = 4'h2;
  localparam logic [DOP_KIND_W-1:0] DOP_COPY = 4'h3;
  localparam logic [DOP_KIND_W-1:0] DOP_SYNC = 4'hf;

  // Queue depths and sync window
  localparam int WORKQ_DEPTH = 8;
  localparam int ACKQ_DEPTH  = 8;
  localparam int SYNC_MAX    = 4;
  localparam int SYNC_PTR_W  = $clog2(SYNC_MAX);
  localparam int SYNC_CNT_W  = $clog2(SYNC_MAX + 1);

  // Unlisted opcodes give DOP_NOP, i.e. no element DOps
  function automatic logic [DOP_KIND_W-1:0] iop_to_dop_kind(
    input logic [IOP_FIELD_W-1:0] opc
  );
    case (opc)
      IOP_ADD:  return DOP_ADD;
      IOP_MUL:  return DOP_MUL;
      IOP_COPY: return DOP_COPY;
      default:  return DOP_NOP;
    endcase
  endfunction

endpackage
